//--- hw/qla_cfg.svh
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// Motor channels on the board (1 to 15)
`define QLA_NUM_CHAN        4

// Command FIFO depth, also the host's starting command credits
`define QLA_CMD_FIFO_DEPTH  4

// Response credits held by the controller after reset
`define QLA_RSP_CREDITS     2

// Board unit registers (unit 0)
`define QLA_REG_BOARD_ID    4'h0
`define QLA_REG_TIMESTAMP   4'h1

// Channel unit registers (units 1 to N)
`define QLA_REG_SETPOINT    4'h0
`define QLA_REG_LIMIT       4'h1
`define QLA_REG_APPLIED     4'h2

`endif

//--- hw/qla_pkg.sv
package qla_pkg;

    typedef logic [15:0] reg_addr_t;    // Bits 7:4 unit, 3:0 register
    typedef logic [31:0] reg_data_t;
    typedef logic [3:0]  chan_t;        // 0 is the board, 1 to N channels
    typedef logic [15:0] dac_t;         // Unsigned setpoint
    typedef logic [31:0] timestamp_t;   // Free-running sysclk count

    // Host command kinds
    typedef enum logic [1:0] {
        QWRITE  = 2'd0,
        QREAD   = 2'd1,
        RTWRITE = 2'd2,
        SAMPLE  = 2'd3
    } cmd_op_e;

    // Command controller FSM
    typedef enum logic [1:0] {
        CTRL_IDLE,      // Free to pop
        CTRL_EXEC,      // Bus access for the popped command
        CTRL_RSP,       // Read word waiting for a credit
        CTRL_SAMPLE     // Sampler owns the read bus
    } ctrl_state_e;

    // Sampler FSM
    typedef enum logic [1:0] {
        SMP_IDLE,
        SMP_TIME,       // Timestamp word
        SMP_CHAN        // Applied value of one channel
    } sample_state_e;

endpackage

//--- hw/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if import qla_pkg::*; ();

    reg_addr_t host_raddr;  // Controller read address (zero while sampling)
    reg_addr_t smp_raddr;   // Sampler read address (zero when idle)
    reg_addr_t raddr;       // Merged read address seen by the slave
    reg_addr_t waddr;
    reg_data_t rdata;       // Combinational, follows raddr
    reg_data_t wdata;
    logic      wen;         // Write strobe
    logic      blk_wen;     // Word belongs to a real-time block
    logic      blk_wstart;  // First word of a block

    // Only one side drives a nonzero address at a time
    assign raddr = host_raddr | smp_raddr;

    modport master (
        output host_raddr, waddr, wdata, wen, blk_wen, blk_wstart,
        input  rdata
    );

    modport sampler (
        output smp_raddr,
        input  rdata
    );

    modport slave (
        input  raddr, waddr, wdata, wen, blk_wen, blk_wstart,
        output rdata
    );

endinterface

//--- hw/host_cmd_ctrl.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module host_cmd_ctrl import qla_pkg::*; (
    input  logic      sysclk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  cmd_op_e   cmd_op,
    input  reg_addr_t cmd_addr,
    input  reg_data_t cmd_data,
    input  logic      rsp_credit,
    input  logic      sample_busy,
    input  logic      sample_valid,
    input  reg_data_t sample_data,
    output logic      cmd_credit,
    output logic      rsp_valid,
    output reg_data_t rsp_data,
    output logic      sample_start,
    output logic      sample_ack,
    reg_bus_if.master bus
);

    localparam int DEPTH    = `QLA_CMD_FIFO_DEPTH;
    localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int CREDIT_W = $clog2(`QLA_RSP_CREDITS + 1);

    // Command FIFO storage
    cmd_op_e   fifo_op   [DEPTH];
    reg_addr_t fifo_addr [DEPTH];
    reg_data_t fifo_data [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic push, pop;

    ctrl_state_e state;
    cmd_op_e     cur_op;        // Command being executed
    reg_addr_t   cur_addr;
    reg_data_t   cur_data;
    reg_data_t   rsp_hold;      // QREAD word awaiting a credit
    chan_t       rt_chan;       // Next real-time channel
    logic [CREDIT_W-1:0] rsp_cnt;
    logic exec, blk_wr, host_send;

    assign push = cmd_valid && (fifo_cnt != CNT_W'(DEPTH));  // Host only sends with a credit
    // One pop per cycle, never with a response pending or sampler active
    assign pop  = (fifo_cnt != '0) && (state == CTRL_IDLE) && !sample_busy;

    always_ff @(posedge sysclk) begin
        if (push) begin
            fifo_op[wr_ptr]   <= cmd_op;
            fifo_addr[wr_ptr] <= cmd_addr;
            fifo_data[wr_ptr] <= cmd_data;
        end
        if (pop) begin
            cur_op   <= fifo_op[rd_ptr];
            cur_addr <= fifo_addr[rd_ptr];
            cur_data <= fifo_data[rd_ptr];
        end
        if (exec && cur_op == QREAD)
            rsp_hold <= bus.rdata;  // Read lands one cycle after pop
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fifo_cnt   <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
            cmd_credit <= pop;      // One credit back per popped command
        end
    end

    // Decode FSM
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= CTRL_IDLE;
        end else begin
            case (state)
                CTRL_IDLE:   if (pop) state <= CTRL_EXEC;
                CTRL_EXEC: begin
                    case (cur_op)
                        QREAD:   state <= CTRL_RSP;
                        SAMPLE:  state <= CTRL_SAMPLE;
                        default: state <= CTRL_IDLE;   // Writes finish here
                    endcase
                end
                CTRL_RSP:    if (host_send) state <= CTRL_IDLE;
                CTRL_SAMPLE: if (!sample_busy) state <= CTRL_IDLE;
                default:     state <= CTRL_IDLE;
            endcase
        end
    end

    // Real-time channel sequence and response credits
    always_ff @(posedge sysclk) begin
        if (rst) begin
            rt_chan <= chan_t'(1);
            rsp_cnt <= CREDIT_W'(`QLA_RSP_CREDITS);
        end else begin
            if (exec && cur_op == QWRITE)
                rt_chan <= chan_t'(1);  // Any quadlet write restarts the block
            else if (blk_wr)
                rt_chan <= (rt_chan == chan_t'(`QLA_NUM_CHAN)) ? chan_t'(1) : rt_chan + 1'b1;
            rsp_cnt <= rsp_cnt + CREDIT_W'(rsp_credit) - CREDIT_W'(rsp_valid);
        end
    end

    assign exec   = (state == CTRL_EXEC);
    assign blk_wr = exec && (cur_op == RTWRITE);

    // Write bus, driven during the cycle after pop
    always_comb begin
        bus.wen        = exec && (cur_op == QWRITE || cur_op == RTWRITE);
        bus.blk_wen    = blk_wr;
        bus.blk_wstart = blk_wr && (rt_chan == chan_t'(1));
        bus.waddr      = blk_wr ? {8'h00, rt_chan, `QLA_REG_SETPOINT} : cur_addr;
        bus.wdata      = blk_wr ? {16'h0000, cur_data[15:0]} : cur_data;
        bus.host_raddr = sample_busy ? '0 : cur_addr;  // Yield to sampler
    end

    assign sample_start = exec && (cur_op == SAMPLE);

    // Single response port, sampler words merged in
    assign host_send  = (state == CTRL_RSP) && (rsp_cnt != '0);
    assign sample_ack = (state == CTRL_SAMPLE) && sample_valid && (rsp_cnt != '0);
    assign rsp_valid  = host_send || sample_ack;
    assign rsp_data   = sample_ack ? sample_data : rsp_hold;

endmodule

//--- hw/sample_ctrl.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module sample_ctrl import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic       sample_start,  // From command decode
    input  logic       sample_ack,    // Word taken by response path
    output logic       sample_busy,
    output logic       sample_valid,
    output reg_data_t  sample_data,
    reg_bus_if.sampler bus
);

    sample_state_e state;
    chan_t         chan;      // Channel being read

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= SMP_IDLE;
            chan  <= chan_t'(1);
        end else begin
            case (state)
                SMP_IDLE: begin
                    if (sample_start)
                        state <= SMP_TIME;
                end
                SMP_TIME: begin
                    if (sample_ack) begin
                        state <= SMP_CHAN;
                        chan  <= chan_t'(1);
                    end
                end
                SMP_CHAN: begin
                    if (sample_ack) begin
                        if (chan == chan_t'(`QLA_NUM_CHAN))
                            state <= SMP_IDLE;    // Last channel sent
                        else
                            chan <= chan + 1'b1;
                    end
                end
                default: state <= SMP_IDLE;
            endcase
        end
    end

    // Read address for the current word
    always_comb begin
        case (state)
            SMP_TIME: bus.smp_raddr = {8'h00, 4'h0, `QLA_REG_TIMESTAMP};
            SMP_CHAN: bus.smp_raddr = {8'h00, chan, `QLA_REG_APPLIED};
            default:  bus.smp_raddr = '0;   // Leave the bus to the controller
        endcase
    end

    assign sample_busy  = (state != SMP_IDLE);
    assign sample_valid = sample_busy;     // Every busy cycle offers a word
    assign sample_data  = bus.rdata;       // Combinational read, held until ack

endmodule

//--- hw/motor_channels.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module motor_channels import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,
    reg_bus_if.slave   bus
);

    localparam int NUM_CHAN = `QLA_NUM_CHAN;

    // Per-channel register views for the read mux
    dac_t setpoint [1:NUM_CHAN];
    dac_t limit    [1:NUM_CHAN];
    dac_t applied  [1:NUM_CHAN];

    timestamp_t timestamp;
    logic       blk_open;     // Inside a started real-time block
    logic       wr_ok;
    chan_t      rd_unit;
    logic [3:0] rd_reg;

    always_ff @(posedge sysclk) begin
        if (rst)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    // Block words only count after a block start
    assign wr_ok = !bus.blk_wen || bus.blk_wstart || blk_open;

    always_ff @(posedge sysclk) begin
        if (rst)
            blk_open <= 1'b0;
        else if (bus.wen)
            blk_open <= bus.blk_wen && wr_ok;  // Plain write closes the block
    end

    for (genvar i = 1; i <= NUM_CHAN; i++) begin : g_chan
        dac_t sp_q;
        dac_t lim_q;
        dac_t app_q;
        logic unit_hit;

        assign unit_hit = (bus.waddr[15:8] == 8'h00) && (bus.waddr[7:4] == chan_t'(i));

        always_ff @(posedge sysclk) begin
            if (rst) begin
                sp_q  <= '0;
                lim_q <= 16'hFFFF;    // No clamping until a limit is set
                app_q <= '0;
            end else begin
                if (bus.wen && unit_hit && wr_ok) begin
                    case (bus.waddr[3:0])
                        `QLA_REG_SETPOINT: sp_q  <= bus.wdata[15:0];
                        `QLA_REG_LIMIT:    lim_q <= bus.wdata[15:0];
                        default: ;        // Applied value is read-only
                    endcase
                end
                app_q <= (sp_q < lim_q) ? sp_q : lim_q;   // Clamp, one cycle behind
            end
        end

        assign setpoint[i] = sp_q;
        assign limit[i]    = lim_q;
        assign applied[i]  = app_q;
    end

    assign rd_unit = bus.raddr[7:4];
    assign rd_reg  = bus.raddr[3:0];

    // Combinational read decode
    always_comb begin
        bus.rdata = '0;                   // Unmapped reads return zero
        if (bus.raddr[15:8] == 8'h00) begin
            if (rd_unit == 4'h0) begin
                case (rd_reg)
                    `QLA_REG_BOARD_ID:  bus.rdata = {20'h0, chan_t'(NUM_CHAN), 4'h0, board_id};
                    `QLA_REG_TIMESTAMP: bus.rdata = timestamp;
                    default: ;
                endcase
            end else if (rd_unit <= chan_t'(NUM_CHAN)) begin
                case (rd_reg)
                    `QLA_REG_SETPOINT: bus.rdata = {16'h0000, setpoint[rd_unit]};
                    `QLA_REG_LIMIT:    bus.rdata = {16'h0000, limit[rd_unit]};
                    `QLA_REG_APPLIED:  bus.rdata = {16'h0000, applied[rd_unit]};
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hw/board_top.sv
`timescale 1ns/1ps

module board_top import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,     // Board number
    // Host command stream
    input  logic       cmd_valid,
    input  cmd_op_e    cmd_op,
    input  reg_addr_t  cmd_addr,
    input  reg_data_t  cmd_data,
    output logic       cmd_credit,
    // Host response stream
    input  logic       rsp_credit,
    output logic       rsp_valid,
    output reg_data_t  rsp_data
);

    // Sampler handshake
    logic      sample_start;
    logic      sample_busy;   // Sampler holds the read bus
    logic      sample_valid;
    logic      sample_ack;
    reg_data_t sample_data;

    reg_bus_if bus ();        // Shared register bus

    host_cmd_ctrl host_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .rsp_credit   (rsp_credit),
        .sample_busy  (sample_busy),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .cmd_credit   (cmd_credit),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .sample_start (sample_start),
        .sample_ack   (sample_ack),
        .bus          (bus.master)
    );

    sample_ctrl sample_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .sample_start (sample_start),
        .sample_ack   (sample_ack),
        .sample_busy  (sample_busy),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .bus          (bus.sampler)
    );

    motor_channels chan_i (
        .sysclk   (sysclk),
        .rst      (rst),
        .board_id (board_id),
        .bus      (bus.slave)
    );

endmodule

//--- tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int RST_CYCLES = 4
) (
    output logic sysclk,
    output logic rst
);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;
    end

endmodule

//--- tests/board_properties.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module board_properties (
    input logic sysclk,
    input logic rst,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic rsp_valid,
    input logic rsp_credit,
    input logic wen,
    input logic sample_busy
);

    int cmd_out;      // Commands sent whose credit is not yet back
    int rsp_avail;    // Response credits held by the controller

    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd_out   <= 0;
            rsp_avail <= `QLA_RSP_CREDITS;
        end else begin
            cmd_out   <= cmd_out + int'(cmd_valid) - int'(cmd_credit);
            rsp_avail <= rsp_avail + int'(rsp_credit) - int'(rsp_valid);
        end
    end

    // Outstanding count stays between zero and the FIFO depth
    cmd_window: assert property (@(posedge sysclk) disable iff (rst)
        cmd_out >= 0 && cmd_out <= `QLA_CMD_FIFO_DEPTH)
        else $error("command credits out of step with the commands sent");

    rsp_needs_credit: assert property (@(posedge sysclk) disable iff (rst)
        rsp_valid |-> rsp_avail != 0)
        else $error("rsp_valid fired with no response credit left");

    // Strobes quiet in the cycle after a reset edge
    reset_quiet: assert property (@(posedge sysclk)
        $past(rst) |-> !wen && !sample_busy && !rsp_valid && !cmd_credit)
        else $error("bus write, sampler or stream active right after reset");

endmodule

bind board_top board_properties props_i (
    .sysclk      (sysclk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_credit  (cmd_credit),
    .rsp_valid   (rsp_valid),
    .rsp_credit  (rsp_credit),
    .wen         (bus.wen),
    .sample_busy (sample_busy)
);

//--- tests/tb_checker.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module tb_checker import qla_pkg::*; (
    input  logic       sysclk,
    input  logic       rst,
    input  logic [3:0] board_id,
    input  logic       cmd_valid,
    input  cmd_op_e    cmd_op,
    input  reg_addr_t  cmd_addr,
    input  reg_data_t  cmd_data,
    input  logic       cmd_credit,
    input  logic       rsp_valid,
    input  reg_data_t  rsp_data,
    output int         mismatches,
    output int         other_errors,
    output int         pending          // Responses still owed
);

    localparam int N = `QLA_NUM_CHAN;

    dac_t        sp_m  [1:N];           // Shadow setpoints
    dac_t        lim_m [1:N];           // Shadow limits
    int          rt_next;               // Next real-time channel
    logic [32:0] exp_q [$];             // Bit 32 marks a timestamp word
    logic [32:0] head;
    timestamp_t  last_ts;
    int          cmds_seen;
    int          credits_seen;

    // Expected read by the register map, timestamp handled by the caller
    function automatic reg_data_t expected_read(input reg_addr_t addr);
        int unit;
        unit = int'(addr[7:4]);
        if (addr[15:8] != 8'h00 || unit > N)
            return '0;
        if (unit == 0)
            return (addr[3:0] == 4'h0) ? reg_data_t'((N << 8) | int'(board_id)) : '0;
        case (addr[3:0])
            4'h0:    return {16'h0000, sp_m[unit]};
            4'h1:    return {16'h0000, lim_m[unit]};
            4'h2:    return {16'h0000, (sp_m[unit] < lim_m[unit]) ? sp_m[unit] : lim_m[unit]};
            default: return '0;
        endcase
    endfunction

    task automatic write_shadow(input reg_addr_t addr, input dac_t value);
        int unit;
        unit = int'(addr[7:4]);
        if (addr[15:8] == 8'h00 && unit >= 1 && unit <= N) begin
            if (addr[3:0] == 4'h0)
                sp_m[unit] = value;
            else if (addr[3:0] == 4'h1)
                lim_m[unit] = value;    // Applied register ignores writes
        end
    endtask

    always @(posedge sysclk) begin
        if (rst) begin
            for (int i = 1; i <= N; i++) begin
                sp_m[i]  = '0;
                lim_m[i] = 16'hffff;
            end
            rt_next      = 1;
            last_ts      = '0;
            cmds_seen    = 0;
            credits_seen = 0;
            mismatches   = 0;
            other_errors = 0;
            exp_q.delete();
        end else begin
            // Responses first, a command is never answered in its own cycle
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("response %h arrived with no command waiting for it", rsp_data);
                end else begin
                    head = exp_q.pop_front();
                    if (head[32] && rsp_data <= last_ts) begin
                        mismatches++;
                        $display("mismatch rsp_data: timestamp %h not above %h", rsp_data, last_ts);
                    end else if (!head[32] && rsp_data !== head[31:0]) begin
                        mismatches++;
                        $display("mismatch rsp_data: expected %h got %h", head[31:0], rsp_data);
                    end
                    if (head[32])
                        last_ts = rsp_data;
                end
            end
            if (cmd_valid) begin
                cmds_seen++;
                case (cmd_op)
                    QWRITE: begin
                        write_shadow(cmd_addr, cmd_data[15:0]);
                        rt_next = 1;            // Block sequence restarts
                    end
                    RTWRITE: begin
                        write_shadow({8'h00, 4'(rt_next), 4'h0}, cmd_data[15:0]);
                        rt_next = (rt_next == N) ? 1 : rt_next + 1;
                    end
                    QREAD: exp_q.push_back({cmd_addr == 16'h0001, expected_read(cmd_addr)});
                    SAMPLE: begin
                        exp_q.push_back({1'b1, 32'h0});     // Timestamp leads
                        for (int i = 1; i <= N; i++)
                            exp_q.push_back({1'b0, expected_read({8'h00, 4'(i), 4'h2})});
                    end
                endcase
            end
            if (cmd_credit) begin
                credits_seen++;
                if (credits_seen > cmds_seen) begin
                    other_errors++;
                    $display("cmd_credit pulse %0d with only %0d commands sent",
                             credits_seen, cmds_seen);
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps

`include "qla_cfg.svh"

module tb_top import qla_pkg::*; ();

    localparam int N       = `QLA_NUM_CHAN;
    localparam int DEPTH   = `QLA_CMD_FIFO_DEPTH;
    localparam int SEED    = 32'he4fe;
    localparam int N_RAND  = 48;
    // Commands per test: 1, 3N+10, 3N+1, 2, N_RAND
    localparam int N_CMDS  = 14 + 6 * N + N_RAND;
    localparam int TIMEOUT = 40 * N_CMDS;

    logic       sysclk;
    logic       rst;
    logic [3:0] board_id;
    logic       cmd_valid;
    cmd_op_e    cmd_op;
    reg_addr_t  cmd_addr;
    reg_data_t  cmd_data;
    logic       cmd_credit;
    logic       rsp_credit;
    logic       rsp_valid;
    reg_data_t  rsp_data;

    int mismatches, other_errors, pending;
    int seed         = SEED;
    int credit_seed  = SEED;
    int cmd_sent     = 0;       // Host command credits spent
    int credits_got  = 0;       // and returned
    int rsp_seen     = 0;       // Response credits owed to the DUT
    int credits_back = 0;
    int cycles       = 0;
    bit fast_credit  = 1'b1;    // Return response credits at once

    clk_gen clk_i (.sysclk(sysclk), .rst(rst));

    board_top dut_i (
        .sysclk     (sysclk),
        .rst        (rst),
        .board_id   (board_id),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    tb_checker chk_i (
        .sysclk       (sysclk),
        .rst          (rst),
        .board_id     (board_id),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_data     (cmd_data),
        .cmd_credit   (cmd_credit),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .pending      (pending)
    );

    always @(posedge sysclk) begin
        cycles++;
        if (cmd_credit)
            credits_got++;
        if (rsp_valid)
            rsp_seen++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, %0d responses never arrived", cycles, pending);
            $display("TB FAILED");
            $finish;
        end
    end

    // Host response side, one credit back per response taken
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(negedge sysclk);
            rsp_credit = 1'b0;
            if (rsp_seen > credits_back &&
                (fast_credit || $unsigned($random(credit_seed)) % 12 == 0)) begin
                rsp_credit = 1'b1;
                credits_back++;
            end
        end
    end

    // Called on a falling edge, waits for a command credit
    task automatic send_cmd(input cmd_op_e op, input reg_addr_t addr, input reg_data_t data);
        while (cmd_sent - credits_got >= DEPTH)
            @(negedge sysclk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        cmd_sent++;
        @(negedge sysclk);
        cmd_valid = 1'b0;
    endtask

    function automatic reg_addr_t chan_addr(input int unit, input logic [3:0] r);
        return {8'h00, 4'(unit), r};
    endfunction

    // Mode flips on a rising edge so the credit process never races it
    task automatic set_credit_mode(input bit fast);
        @(posedge sysclk);
        fast_credit = fast;
        @(negedge sysclk);
    endtask

    initial begin
        logic [1:0] pick;
        int         unit;
        int         r;
        cmd_valid = 1'b0;
        cmd_op    = QWRITE;
        cmd_addr  = '0;
        cmd_data  = '0;
        board_id  = 4'ha;
        @(negedge rst);
        repeat (2) @(negedge sysclk);

        send_cmd(QREAD, 16'h0000, '0);          // Board id and channel count

        for (int i = 1; i <= N; i++) begin
            send_cmd(QWRITE, chan_addr(i, 4'h0), $random(seed));
            send_cmd(QWRITE, chan_addr(i, 4'h1), $random(seed));
            send_cmd(QREAD, chan_addr(i, 4'h2), '0);
        end
        // Read-only and unmapped addresses
        send_cmd(QWRITE, chan_addr(1, 4'h2), 32'h0000_1234);
        send_cmd(QREAD, chan_addr(1, 4'h2), '0);
        send_cmd(QWRITE, 16'h0000, 32'hffff_ffff);
        send_cmd(QREAD, 16'h0000, '0);
        send_cmd(QREAD, 16'h0001, '0);          // Timestamp
        send_cmd(QREAD, chan_addr(1, 4'h0), '0);
        send_cmd(QREAD, chan_addr(1, 4'h1), '0);
        send_cmd(QREAD, chan_addr(1, 4'h3), '0);
        send_cmd(QREAD, chan_addr(N + 1, 4'h0), '0);
        send_cmd(QREAD, 16'h0110, '0);

        // Two rounds of real-time setpoints after a restart
        send_cmd(QWRITE, chan_addr(1, 4'h1), 32'h0000_8000);
        for (int i = 0; i < 2 * N; i++)
            send_cmd(RTWRITE, '0, $random(seed));
        for (int i = 1; i <= N; i++)
            send_cmd(QREAD, chan_addr(i, 4'h2), '0);

        send_cmd(SAMPLE, '0, '0);
        send_cmd(SAMPLE, '0, '0);

        // Mixed traffic with response credits held back
        set_credit_mode(1'b0);
        for (int i = 0; i < N_RAND; i++) begin
            pick = 2'($random(seed));
            unit = $unsigned($random(seed)) % (N + 1);
            r    = $unsigned($random(seed)) % 3;
            send_cmd(cmd_op_e'(pick), chan_addr(unit, 4'(r)), $random(seed));
        end
        set_credit_mode(1'b1);

        while (pending != 0)
            @(negedge sysclk);
        repeat (10) @(negedge sysclk);          // Catch stray responses

        $display("errors: %0d mismatches, %0d other failures, %0d commands sent",
                 mismatches, other_errors, cmd_sent);
        if (mismatches == 0 && other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/qla_pkg.sv
hw/reg_bus_if.sv
hw/host_cmd_ctrl.sv
hw/sample_ctrl.sv
hw/motor_channels.sv
hw/board_top.sv
tests/clk_gen.sv
tests/board_properties.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= tb_top
FILELIST ?= build.f
FLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
